// File: logic/gfx_pkg.sv
package gfx_pkg;

    // RGB444 pixel, red in the top nibble
    typedef logic [11:0] color_t;

    // Pixel coordinate, enough for frames up to 255 on a side
    typedef logic [7:0] coord_t;

    // Background above the horizontal centre
    localparam color_t color_above = 12'h0AF;

    // Centre row and everything below it
    localparam color_t color_below = 12'hAAA;

endpackage

// File: logic/fb_pkg.sv
package fb_pkg;

    import gfx_pkg::*;

    // Linear pixel address y*width+x, sized for a 160x120 frame
    typedef logic [14:0] fb_addr_t;

    // Write request into the selected bank
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        color_t   data;
    } fb_write_t;

    // Read request from the bank that is not selected
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
    } fb_read_t;

endpackage

// File: logic/background_drawer.sv
`timescale 1ns/10ps

module background_drawer
    import gfx_pkg::*;
    import fb_pkg::*;
#(
    parameter int frame_width  = 160,
    parameter int frame_height = 120
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      draw_start,
    output logic      draw_done,
    output fb_write_t wr
);

    localparam int     pixel_count = frame_width * frame_height;
    localparam coord_t last_x      = coord_t'(frame_width - 1);
    localparam coord_t last_y      = coord_t'(frame_height - 1);
    localparam coord_t half_y      = coord_t'(frame_height / 2);

    typedef enum logic [0:0] {
        idle,
        drawing
    } state_t;

    state_t state;
    coord_t x;
    coord_t y;
    logic   last_pixel;

    assign last_pixel = (x == last_x) && (y == last_y);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (draw_start) begin
                        state <= drawing;
                    end
                end
                drawing: begin
                    if (last_pixel) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Row-by-row scan, x runs fastest
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x <= '0;
            y <= '0;
        end else if (state == idle) begin
            if (draw_start) begin
                x <= '0;
                y <= '0;
            end
        end else if (x == last_x) begin
            x <= '0;
            y <= (y == last_y) ? '0 : y + 1'b1;
        end else begin
            x <= x + 1'b1;
        end
    end

    // One write per drawing cycle, done comes with the last one
    always_comb begin
        wr.en     = (state == drawing);
        wr.addr   = fb_addr_t'(y) * fb_addr_t'(frame_width) + fb_addr_t'(x);
        wr.data   = (y < half_y) ? color_above : color_below;
        draw_done = (state == drawing) && last_pixel;
    end

    a_wr_in_frame: assert property (@(posedge clk) disable iff (!rstn)
        wr.en |-> (wr.addr < fb_addr_t'(pixel_count)));

endmodule

// File: logic/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer
    import gfx_pkg::*;
    import fb_pkg::*;
#(
    parameter int frame_width  = 160,
    parameter int frame_height = 120
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      buffer_select,
    input  fb_write_t wr,
    input  fb_read_t  rd,
    output color_t    rd_data
);

    localparam int pixel_count = frame_width * frame_height;
    localparam int index_bits  = $clog2(pixel_count);

    // Two banks, one per buffer_select value
    color_t bank_mem [2][pixel_count];

    logic                  rd_bank;
    logic [index_bits-1:0] wr_index;
    logic [index_bits-1:0] rd_index;

    assign rd_bank  = ~buffer_select;
    assign wr_index = wr.addr[index_bits-1:0];
    assign rd_index = rd.addr[index_bits-1:0];

    // Drawer side writes the selected bank
    always_ff @(posedge clk) begin
        if (wr.en) begin
            bank_mem[buffer_select][wr_index] <= wr.data;
        end
    end

    // Scanner side reads the other bank, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= bank_mem[rd_bank][rd_index];
        end
    end

    a_wr_addr_range: assert property (@(posedge clk) disable iff (!rstn)
        wr.en |-> (wr.addr < fb_addr_t'(pixel_count)));

    a_rd_addr_range: assert property (@(posedge clk) disable iff (!rstn)
        rd.en |-> (rd.addr < fb_addr_t'(pixel_count)));

endmodule

// File: logic/pixel_scanner.sv
`timescale 1ns/10ps

module pixel_scanner
    import gfx_pkg::*;
    import fb_pkg::*;
#(
    parameter int frame_width  = 160,
    parameter int frame_height = 120
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     scan_start,
    output fb_read_t rd,
    input  color_t   rd_data,
    output color_t   pixel_data,
    output logic     pixel_valid,
    input  logic     pixel_ready,
    output logic     pixel_last
);

    localparam int       pixel_count = frame_width * frame_height;
    localparam fb_addr_t last_addr   = fb_addr_t'(pixel_count - 1);

    typedef enum logic [1:0] {
        idle,
        scanning,
        draining
    } state_t;

    typedef struct packed {
        color_t data;
        logic   last;
    } entry_t;

    state_t     state;
    fb_addr_t   addr;
    logic       pending;
    logic       pending_last;
    logic       out_valid;
    logic       skid_valid;
    entry_t     out_entry;
    entry_t     skid_entry;
    entry_t     rd_entry;
    logic       fire;
    logic       out_load;
    logic [1:0] occupancy;

    assign rd_entry  = '{data: rd_data, last: pending_last};
    assign fire      = out_valid && pixel_ready;
    assign out_load  = !out_valid || pixel_ready;
    assign occupancy = 2'(out_valid) + 2'(skid_valid) + 2'(pending);

    // Read only if the returning pixel still finds a free slot
    assign rd.en   = (state == scanning) && ((occupancy - {1'b0, fire}) <= 2'd1);
    assign rd.addr = addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state        <= idle;
            addr         <= '0;
            pending      <= 1'b0;
            pending_last <= 1'b0;
        end else begin
            pending      <= rd.en;
            pending_last <= rd.en && (addr == last_addr);
            case (state)
                idle: begin
                    if (scan_start) begin
                        state <= scanning;
                        addr  <= '0;
                    end
                end
                scanning: begin
                    if (rd.en) begin
                        addr <= addr + 1'b1;
                        if (addr == last_addr) begin
                            state <= draining;
                        end
                    end
                end
                draining: begin
                    if (fire && out_entry.last) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            out_valid  <= skid_valid || pending;
            skid_valid <= skid_valid && pending;
        end else begin
            skid_valid <= skid_valid || pending;
        end
    end

    // Skid entry feeds the output first, then fresh read data
    always_ff @(posedge clk) begin
        if (out_load) begin
            out_entry <= skid_valid ? skid_entry : rd_entry;
        end
        if (pending && (skid_valid || !out_load)) begin
            skid_entry <= rd_entry;
        end
    end

    assign pixel_data  = out_entry.data;
    assign pixel_valid = out_valid;
    assign pixel_last  = out_valid && out_entry.last;

    a_stall_stable: assert property (@(posedge clk) disable iff (!rstn)
        pixel_valid && !pixel_ready |=>
            pixel_valid && $stable(pixel_data) && $stable(pixel_last));

endmodule

// File: logic/display_pipeline_top.sv
`timescale 1ns/10ps

module display_pipeline_top
    import gfx_pkg::*;
    import fb_pkg::*;
#(
    parameter int frame_width  = 160,
    parameter int frame_height = 120
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   draw_start,
    output logic   draw_done,
    input  logic   buffer_select,
    input  logic   scan_start,
    output color_t pixel_data,
    output logic   pixel_valid,
    input  logic   pixel_ready,
    output logic   pixel_last
);

    fb_write_t fb_wr;
    fb_read_t  fb_rd;
    color_t    fb_rd_data;

    // Fills the bank named by buffer_select
    background_drawer #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) i_drawer (
        .clk        (clk),
        .rstn       (rstn),
        .draw_start (draw_start),
        .draw_done  (draw_done),
        .wr         (fb_wr)
    );

    frame_buffer #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) i_frame_buffer (
        .clk           (clk),
        .rstn          (rstn),
        .buffer_select (buffer_select),
        .wr            (fb_wr),
        .rd            (fb_rd),
        .rd_data       (fb_rd_data)
    );

    // Streams the other bank out in raster order
    pixel_scanner #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) i_scanner (
        .clk         (clk),
        .rstn        (rstn),
        .scan_start  (scan_start),
        .rd          (fb_rd),
        .rd_data     (fb_rd_data),
        .pixel_data  (pixel_data),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel_last  (pixel_last)
    );

endmodule

// File: verification/tb_display_pipeline.sv
`timescale 1ns/10ps

module tb_display_pipeline
    import gfx_pkg::*;
();

    localparam int frame_width     = 16;
    localparam int frame_height    = 12;
    localparam int pixel_count     = frame_width * frame_height;
    localparam int clk_period      = 20;
    localparam int scan_count      = 4;
    localparam int draw_count      = 2;
    localparam int watchdog_cycles = (scan_count + draw_count) * pixel_count * 4 + 200;

    // Split background as seen on the stream
    localparam color_t ref_above = 12'h0AF;
    localparam color_t ref_below = 12'hAAA;

    logic   clk;
    logic   rstn;
    logic   draw_start;
    logic   draw_done;
    logic   buffer_select;
    logic   scan_start;
    color_t pixel_data;
    logic   pixel_valid;
    logic   pixel_ready;
    logic   pixel_last;

    int error_count = 0;
    int checks_run  = 0;

    display_pipeline_top #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) i_dut (
        .clk           (clk),
        .rstn          (rstn),
        .draw_start    (draw_start),
        .draw_done     (draw_done),
        .buffer_select (buffer_select),
        .scan_start    (scan_start),
        .pixel_data    (pixel_data),
        .pixel_valid   (pixel_valid),
        .pixel_ready   (pixel_ready),
        .pixel_last    (pixel_last)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    // Rows above the centre row are light blue
    function automatic color_t expected_color(input int pix_index);
        if ((pix_index / frame_width) < (frame_height / 2)) begin
            return ref_above;
        end
        return ref_below;
    endfunction

    task automatic check_color(input color_t got, input color_t exp, input string what);
        checks_run++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %03h, expected %03h", $time, what, got, exp);
        end
    endtask

    task automatic expect_flag(input logic got, input logic exp, input string what);
        checks_run++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks_run++;
        if (got != exp) begin
            error_count++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Cycle 1 holds pixel 0, so done belongs on cycle pixel_count
    task automatic draw_frame(input bit restart_mid, input string label);
        int cycle;
        int done_pulses;
        int done_cycle;
        done_pulses = 0;
        done_cycle  = 0;
        @(negedge clk);
        draw_start = 1'b1;
        for (cycle = 1; cycle <= 2 * pixel_count; cycle++) begin
            @(negedge clk);
            draw_start = restart_mid && (cycle == pixel_count / 3);
            if (draw_done) begin
                done_pulses++;
                done_cycle = cycle;
            end
        end
        draw_start = 1'b0;
        compare_count(done_pulses, 1, {label, " done pulses"});
        compare_count(done_cycle, pixel_count, {label, " cycles to done"});
    endtask

    // Ready is decided on the falling edge, the transfer happens on the next rising edge
    task automatic scan_frame(input bit random_ready, input string label);
        int   pix_index;
        bit   got_last;
        logic ready_now;
        pix_index = 0;
        got_last  = 1'b0;
        @(negedge clk);
        scan_start = 1'b1;
        @(negedge clk);
        scan_start = 1'b0;
        while (!got_last && (pix_index < pixel_count)) begin
            if (random_ready) begin
                ready_now = ($urandom % 2) == 1;
            end else begin
                ready_now = 1'b1;
            end
            pixel_ready = ready_now;
            if (pixel_valid && ready_now) begin
                check_color(pixel_data, expected_color(pix_index),
                    $sformatf("%s pixel %0d", label, pix_index));
                expect_flag(pixel_last, pix_index == pixel_count - 1,
                    $sformatf("%s last flag on pixel %0d", label, pix_index));
                got_last = pixel_last;
                pix_index++;
            end
            @(negedge clk);
        end
        pixel_ready = 1'b1;
        compare_count(pix_index, pixel_count, {label, " pixel count"});
        repeat (4) begin
            expect_flag(pixel_valid, 1'b0, {label, " valid after frame"});
            @(negedge clk);
        end
    endtask

    task automatic reset_idle();
        repeat (6) begin
            @(negedge clk);
            expect_flag(draw_done, 1'b0, "draw_done after reset");
            expect_flag(pixel_valid, 1'b0, "pixel_valid after reset");
        end
    endtask

    task automatic draw_timing();
        @(negedge clk);
        buffer_select = 1'b0;
        draw_frame(1'b1, "draw bank 0");
    endtask

    task automatic full_scan();
        @(negedge clk);
        buffer_select = 1'b1;
        scan_frame(1'b0, "full scan");
    endtask

    task automatic backpressure_scan();
        scan_frame(1'b1, "stalled scan");
    endtask

    // Bank 1 is drawn while bank 0 streams out
    task automatic concurrent_draw_scan();
        @(negedge clk);
        buffer_select = 1'b1;
        fork
            begin
                draw_frame(1'b0, "draw bank 1");
            end
            begin
                scan_frame(1'b0, "scan during draw");
            end
        join
        @(negedge clk);
        buffer_select = 1'b0;
        scan_frame(1'b1, "scan bank 1");
    endtask

    initial begin
        rstn          = 1'b0;
        draw_start    = 1'b0;
        buffer_select = 1'b0;
        scan_start    = 1'b0;
        pixel_ready   = 1'b1;
        void'($urandom(32'h7217));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        reset_idle();
        draw_timing();
        full_scan();
        backpressure_scan();
        concurrent_draw_scan();

        $display("Checks run: %0d, errors: %0d", checks_run, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
logic/gfx_pkg.sv
logic/fb_pkg.sv
logic/background_drawer.sv
logic/frame_buffer.sv
logic/pixel_scanner.sv
logic/display_pipeline_top.sv
verification/tb_display_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the display pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/10ps \
    --top-module tb_display_pipeline \
    -Mdir obj_dir \
    -f project.f

./obj_dir/Vtb_display_pipeline > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished cleanly"
